// File: Bender.yml
package:
  name: axi_mem

sources:
  - files:
      - common/axi_mem_pkg.sv
      - source/line_ram.sv
      - source/mem_arbiter.sv
      - axi_mem/axi_bresp_queue.sv
      - axi_mem/axi_rd_channel.sv
      - axi_mem/axi_wr_channel.sv
      - axi_mem/axi_mem_top.sv
  - target: test
    files:
      - tests/tb_axi_mem.sv

// File: axi_mem/axi_bresp_queue.sv
`timescale 1ns/10ps
`default_nettype none

module axi_bresp_queue #(
	parameter int unsigned BQ_DEPTH = 4
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             push,
	input  axi_mem_pkg::id_t push_id,
	output logic             full,
	output axi_mem_pkg::id_t b_id,
	output logic             b_valid,
	input  logic             b_ready
);

	localparam int unsigned PTR_W = (BQ_DEPTH > 1) ? $clog2(BQ_DEPTH) : 1;
	localparam int unsigned CNT_W = $clog2(BQ_DEPTH + 1);

	typedef logic [PTR_W-1:0] ptr_t;
	typedef logic [CNT_W-1:0] cnt_t;

	// finished burst IDs in completion order
	axi_mem_pkg::id_t ids [BQ_DEPTH];

	ptr_t wptr;
	ptr_t rptr;
	cnt_t count;
	logic pop;

	assign full = (count == cnt_t'(BQ_DEPTH));
	// head entry shown as soon as one is stored
	assign b_valid = (count != '0);
	assign b_id = ids[rptr];
	assign pop = b_valid && b_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wptr <= '0;
			rptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				// wrap for any depth, not only powers of two
				wptr <= (wptr == ptr_t'(BQ_DEPTH - 1)) ? '0 : wptr + 1'b1;
			end
			if (pop) begin
				rptr <= (rptr == ptr_t'(BQ_DEPTH - 1)) ? '0 : rptr + 1'b1;
			end
			// push and pop together leave the count alone
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			ids[wptr] <= push_id;
		end
	end

endmodule

`default_nettype wire

// File: axi_mem/axi_mem_top.sv
`timescale 1ns/10ps
`default_nettype none

module axi_mem_top #(
	parameter int unsigned LINE_ADDR_W = 10,
	parameter int unsigned BQ_DEPTH = 4
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  axi_mem_pkg::aw_req_t aw,
	input  logic                 aw_valid,
	output logic                 aw_ready,
	input  axi_mem_pkg::w_beat_t w,
	input  logic                 w_valid,
	output logic                 w_ready,
	output axi_mem_pkg::id_t     b_id,
	output logic                 b_valid,
	input  logic                 b_ready,
	input  axi_mem_pkg::ar_req_t ar,
	input  logic                 ar_valid,
	output logic                 ar_ready,
	output axi_mem_pkg::r_beat_t r,
	output logic                 r_valid,
	input  logic                 r_ready
);

	// write side to arbiter
	logic                   wr_req;
	logic                   wr_gnt;
	axi_mem_pkg::mem_wr_t   wr;

	// write side to response FIFO
	logic                   bq_push;
	logic                   bq_full;
	axi_mem_pkg::id_t       bq_id;

	// read side to arbiter
	logic                   rd_req;
	logic                   rd_gnt;
	axi_mem_pkg::addr_t     rd_line;
	axi_mem_pkg::beat_idx_t rd_beat;
	axi_mem_pkg::data_t     rd_data;

	// the one memory port
	logic                   ram_en;
	logic                   ram_we;
	axi_mem_pkg::addr_t     ram_line;
	axi_mem_pkg::beat_idx_t ram_beat;
	axi_mem_pkg::data_t     ram_wdata;
	axi_mem_pkg::strb_t     ram_strb;

	axi_wr_channel #(
		.LINE_ADDR_W(LINE_ADDR_W)
	) wr_ch0 (
		.clk(clk),
		.rst_n(rst_n),
		.aw(aw),
		.aw_valid(aw_valid),
		.aw_ready(aw_ready),
		.w(w),
		.w_valid(w_valid),
		.w_ready(w_ready),
		.wr_req(wr_req),
		.wr(wr),
		.wr_gnt(wr_gnt),
		.bq_push(bq_push),
		.bq_id(bq_id),
		.bq_full(bq_full)
	);

	axi_rd_channel #(
		.LINE_ADDR_W(LINE_ADDR_W)
	) rd_ch0 (
		.clk(clk),
		.rst_n(rst_n),
		.ar(ar),
		.ar_valid(ar_valid),
		.ar_ready(ar_ready),
		.r(r),
		.r_valid(r_valid),
		.r_ready(r_ready),
		.rd_req(rd_req),
		.rd_line(rd_line),
		.rd_beat(rd_beat),
		.rd_gnt(rd_gnt),
		.rd_data(rd_data)
	);

	axi_bresp_queue #(
		.BQ_DEPTH(BQ_DEPTH)
	) bq0 (
		.clk(clk),
		.rst_n(rst_n),
		.push(bq_push),
		.push_id(bq_id),
		.full(bq_full),
		.b_id(b_id),
		.b_valid(b_valid),
		.b_ready(b_ready)
	);

	mem_arbiter arb0 (
		.clk(clk),
		.rst_n(rst_n),
		.wr_req(wr_req),
		.wr(wr),
		.wr_gnt(wr_gnt),
		.rd_req(rd_req),
		.rd_line(rd_line),
		.rd_beat(rd_beat),
		.rd_gnt(rd_gnt),
		.ram_en(ram_en),
		.ram_we(ram_we),
		.ram_line(ram_line),
		.ram_beat(ram_beat),
		.ram_wdata(ram_wdata),
		.ram_strb(ram_strb)
	);

	line_ram #(
		.LINE_ADDR_W(LINE_ADDR_W)
	) ram0 (
		.clk(clk),
		.rst_n(rst_n),
		.en(ram_en),
		.we(ram_we),
		.line(ram_line),
		.beat(ram_beat),
		.wdata(ram_wdata),
		.strb(ram_strb),
		.rdata(rd_data)
	);

endmodule

`default_nettype wire

// File: axi_mem/axi_rd_channel.sv
`timescale 1ns/10ps
`default_nettype none

module axi_rd_channel #(
	parameter int unsigned LINE_ADDR_W = 10
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  axi_mem_pkg::ar_req_t   ar,
	input  logic                   ar_valid,
	output logic                   ar_ready,
	output axi_mem_pkg::r_beat_t   r,
	output logic                   r_valid,
	input  logic                   r_ready,
	output logic                   rd_req,
	output axi_mem_pkg::addr_t     rd_line,
	output axi_mem_pkg::beat_idx_t rd_beat,
	input  logic                   rd_gnt,
	input  axi_mem_pkg::data_t     rd_data
);

	// burst open until its last beat is accepted
	logic                   busy;
	// memory read granted, data arrives this cycle
	logic                   pending;
	logic                   pend_last;

	// burst captured at AR
	axi_mem_pkg::id_t       id_q;
	axi_mem_pkg::addr_t     line_q;
	axi_mem_pkg::beat_idx_t last_q;

	// next beat to fetch
	axi_mem_pkg::beat_idx_t beat_q;

	assign ar_ready = !busy;

	// one beat in flight at most, and none while r is held
	assign rd_req = busy && !pending && !r_valid;
	assign rd_line = line_q;
	assign rd_beat = beat_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			pending <= 1'b0;
			r_valid <= 1'b0;
			beat_q <= '0;
		end else begin
			if (ar_valid && ar_ready) begin
				busy <= 1'b1;
				beat_q <= '0;
			end else if (rd_gnt) begin
				beat_q <= beat_q + 1'b1;
			end
			// ram answers one cycle after the grant
			pending <= rd_gnt;
			if (pending) begin
				r_valid <= 1'b1;
			end else if (r_valid && r_ready) begin
				r_valid <= 1'b0;
				// final beat gone, ar_ready back next cycle
				if (r.last) begin
					busy <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ar_valid && ar_ready) begin
			id_q <= ar.id;
			line_q <= axi_mem_pkg::addr_t'(ar.addr[axi_mem_pkg::LINE_LSB +: LINE_ADDR_W]);
			last_q <= axi_mem_pkg::beat_idx_t'(ar.len);
		end
		// remember if the fetched beat closes the burst
		if (rd_gnt) begin
			pend_last <= (beat_q == last_q);
		end
		// held output beat, loaded only from the ram return
		if (pending) begin
			r.id <= id_q;
			r.data <= rd_data;
			r.last <= pend_last;
		end
	end

endmodule

`default_nettype wire

// File: axi_mem/axi_wr_channel.sv
`timescale 1ns/10ps
`default_nettype none

module axi_wr_channel #(
	parameter int unsigned LINE_ADDR_W = 10
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  axi_mem_pkg::aw_req_t aw,
	input  logic                 aw_valid,
	output logic                 aw_ready,
	input  axi_mem_pkg::w_beat_t w,
	input  logic                 w_valid,
	output logic                 w_ready,
	output logic                 wr_req,
	output axi_mem_pkg::mem_wr_t wr,
	input  logic                 wr_gnt,
	output logic                 bq_push,
	output axi_mem_pkg::id_t     bq_id,
	input  logic                 bq_full
);

	// high between the AW transfer and the last data beat
	logic                   data_phase;

	// burst captured at AW
	axi_mem_pkg::id_t       id_q;
	axi_mem_pkg::addr_t     line_q;
	axi_mem_pkg::beat_idx_t last_q;

	// beat about to be written
	axi_mem_pkg::beat_idx_t beat_q;
	logic                   last_beat;

	// no new burst while one is open or no room for its response
	assign aw_ready = !data_phase && !bq_full;

	// a beat on the bus asks for the memory port
	assign wr_req = data_phase && w_valid;
	// beat accepted only when the arbiter gives the port this cycle
	assign w_ready = wr_req && wr_gnt;

	assign last_beat = (beat_q == last_q);

	// memory write built straight from the bus beat
	assign wr.line = line_q;
	assign wr.beat = beat_q;
	assign wr.data = w.data;
	assign wr.strb = w.strb;

	// response queued on the edge that takes the final beat
	assign bq_push = w_ready && last_beat;
	assign bq_id = id_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			data_phase <= 1'b0;
			beat_q <= '0;
		end else if (aw_valid && aw_ready) begin
			data_phase <= 1'b1;
			beat_q <= '0;
		end else if (w_ready) begin
			beat_q <= beat_q + 1'b1;
			// burst done, aw_ready back next cycle
			if (last_beat) begin
				data_phase <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (aw_valid && aw_ready) begin
			id_q <= aw.id;
			// line index sits above the in-line byte offset
			line_q <= axi_mem_pkg::addr_t'(aw.addr[axi_mem_pkg::LINE_LSB +: LINE_ADDR_W]);
			// one or two beats, so len fits the beat index
			last_q <= axi_mem_pkg::beat_idx_t'(aw.len);
		end
	end

endmodule

`default_nettype wire

// File: common/axi_mem_pkg.sv
`default_nettype none

package axi_mem_pkg;

	// beat and bus widths
	localparam int unsigned DATA_W = 256;
	localparam int unsigned STRB_W = DATA_W / 8;
	localparam int unsigned ID_W = 6;
	localparam int unsigned ADDR_W = 64;
	localparam int unsigned LEN_W = 8;

	// two beats of 256 bits make one line
	localparam int unsigned LINE_BEATS = 2;

	// byte offset bits inside a line, the line index starts above them
	localparam int unsigned LINE_LSB = $clog2(LINE_BEATS * STRB_W);

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [STRB_W-1:0] strb_t;
	typedef logic [ID_W-1:0] id_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [LEN_W-1:0] len_t;

	// beat position inside a line
	typedef logic [$clog2(LINE_BEATS)-1:0] beat_idx_t;

	// write address channel payload
	typedef struct packed {
		id_t id;
		addr_t addr;
		len_t len;
	} aw_req_t;

	// write data beat, wlast not carried
	typedef struct packed {
		data_t data;
		strb_t strb;
	} w_beat_t;

	// read address channel payload
	typedef struct packed {
		id_t id;
		addr_t addr;
		len_t len;
	} ar_req_t;

	// read data beat as seen by the master
	typedef struct packed {
		id_t id;
		data_t data;
		logic last;
	} r_beat_t;

	// one beat write towards the line memory
	// line carried wide, cut to the index width in line_ram
	typedef struct packed {
		addr_t line;
		beat_idx_t beat;
		data_t data;
		strb_t strb;
	} mem_wr_t;

endpackage

`default_nettype wire

// File: compile.f
common/axi_mem_pkg.sv
source/line_ram.sv
source/mem_arbiter.sv
axi_mem/axi_bresp_queue.sv
axi_mem/axi_rd_channel.sv
axi_mem/axi_wr_channel.sv
axi_mem/axi_mem_top.sv
tests/tb_axi_mem.sv

// File: source/line_ram.sv
`timescale 1ns/10ps
`default_nettype none

module line_ram #(
	parameter int unsigned LINE_ADDR_W = 10
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   en,
	input  logic                   we,
	input  axi_mem_pkg::addr_t     line,
	input  axi_mem_pkg::beat_idx_t beat,
	input  axi_mem_pkg::data_t     wdata,
	input  axi_mem_pkg::strb_t     strb,
	output axi_mem_pkg::data_t     rdata
);

	localparam int unsigned LINES = 2 ** LINE_ADDR_W;

	// one row holds every beat of a line
	axi_mem_pkg::data_t mem [LINES][axi_mem_pkg::LINE_BEATS];

	// lines touched since reset
	logic [LINES-1:0] written;

	logic [LINE_ADDR_W-1:0] line_idx;
	axi_mem_pkg::data_t     rdata_q;
	logic                   written_q;

	assign line_idx = line[LINE_ADDR_W-1:0];

	// untouched lines read as zero
	assign rdata = written_q ? rdata_q : '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			written <= '0;
		end else if (en && we) begin
			written[line_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (en && we) begin
			for (int b = 0; b < axi_mem_pkg::LINE_BEATS; b++) begin
				for (int k = 0; k < axi_mem_pkg::STRB_W; k++) begin
					if ((axi_mem_pkg::beat_idx_t'(b) == beat) && strb[k]) begin
						mem[line_idx][b][8*k +: 8] <= wdata[8*k +: 8];
					end else if (!written[line_idx]) begin
						// first write to a line zero-fills the other bytes
						mem[line_idx][b][8*k +: 8] <= 8'h00;
					end
				end
			end
		end
		if (en && !we) begin
			rdata_q <= mem[line_idx][beat];
			written_q <= written[line_idx];
		end
	end

endmodule

`default_nettype wire

// File: source/mem_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   wr_req,
	input  axi_mem_pkg::mem_wr_t   wr,
	output logic                   wr_gnt,
	input  logic                   rd_req,
	input  axi_mem_pkg::addr_t     rd_line,
	input  axi_mem_pkg::beat_idx_t rd_beat,
	output logic                   rd_gnt,
	output logic                   ram_en,
	output logic                   ram_we,
	output axi_mem_pkg::addr_t     ram_line,
	output axi_mem_pkg::beat_idx_t ram_beat,
	output axi_mem_pkg::data_t     ram_wdata,
	output axi_mem_pkg::strb_t     ram_strb
);

	// set when the write side took the port last
	logic last_wr;

	// on a clash the side not served last wins
	assign wr_gnt = wr_req && (!rd_req || !last_wr);
	assign rd_gnt = rd_req && (!wr_req || last_wr);

	// port steered by whichever request won
	assign ram_en = wr_gnt || rd_gnt;
	assign ram_we = wr_gnt;
	assign ram_line = wr_gnt ? wr.line : rd_line;
	assign ram_beat = wr_gnt ? wr.beat : rd_beat;
	assign ram_wdata = wr.data;
	// no byte lanes on a read cycle
	assign ram_strb = wr_gnt ? wr.strb : '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			last_wr <= 1'b0;
		end else if (wr_gnt) begin
			last_wr <= 1'b1;
		end else if (rd_gnt) begin
			last_wr <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: tests/axi_mem_testdata.txt
# W id line len opens a write burst and each D data strb line is one beat
# R id line len opens a read burst and each E data line is one expected beat
# line is the line index in hex and len is beats minus one; P waits for both streams
W 01 005 1
D a0000007a0000006a0000005a0000004a0000003a0000002a0000001a0000000 ffffffff
D b0000007b0000006b0000005b0000004b0000003b0000002b0000001b0000000 ffffffff
W 02 00a 0
D c0000007c0000006c0000005c0000004c0000003c0000002c0000001c0000000 ffffffff
W 03 014 1
D d0000007d0000006d0000005d0000004d0000003d0000002d0000001d0000000 ffffffff
D e1e2e3e7e1e2e3e6e1e2e3e5e1e2e3e4e1e2e3e3e1e2e3e2e1e2e3e1e1e2e3e0 ffffffff
W 04 014 1
D f0000007f0000006f0000005f0000004f0000003f0000002f0000001f0000000 0000ffff
D 9192939791929396919293959192939491929393919293929192939191929390 30c0f00c
W 05 01e 0
D a5a5a5a7a5a5a5a6a5a5a5a5a5a5a5a4a5a5a5a3a5a5a5a2a5a5a5a1a5a5a5a0 8000000f
P
R 11 005 1
E a0000007a0000006a0000005a0000004a0000003a0000002a0000001a0000000
E b0000007b0000006b0000005b0000004b0000003b0000002b0000001b0000000
R 12 00a 1
E c0000007c0000006c0000005c0000004c0000003c0000002c0000001c0000000
E 0
R 13 014 1
E d0000007d0000006d0000005d0000004f0000003f0000002f0000001f0000000
E e1e29397e1e2e3e69192e3e5e1e2e3e491929393e1e2e3e2e1e2e3e19192e3e0
R 14 01e 1
E a5000000000000000000000000000000000000000000000000000000a5a5a5a0
E 0
R 15 100 1
E 0
E 0
W 06 028 1
D 0a0b0c070a0b0c060a0b0c050a0b0c040a0b0c030a0b0c020a0b0c010a0b0c00 ffffffff
D 1a1b1c171a1b1c161a1b1c151a1b1c141a1b1c131a1b1c121a1b1c111a1b1c10 ffffffff
W 07 032 0
D 5c5d5e575c5d5e565c5d5e555c5d5e545c5d5e535c5d5e525c5d5e515c5d5e50 ffffffff
P
R 16 028 1
E 0a0b0c070a0b0c060a0b0c050a0b0c040a0b0c030a0b0c020a0b0c010a0b0c00
E 1a1b1c171a1b1c161a1b1c151a1b1c141a1b1c131a1b1c121a1b1c111a1b1c10
R 17 032 0
E 5c5d5e575c5d5e565c5d5e555c5d5e545c5d5e535c5d5e525c5d5e515c5d5e50
W 08 03c 0
D 3c3c3c3c ffffffff
W 09 03d 0
D 3d3d3d3d ffffffff
W 0a 03e 0
D 3e3e3e3e ffffffff

// File: tests/tb_axi_mem.sv
`timescale 1ns/10ps
`default_nettype none

module tb_axi_mem;

	localparam int MAX_OPS = 32;
	// line index starts at address bit 6 for 64-byte lines
	localparam int LINE_SHIFT = 6;

	logic                 clk;
	logic                 rst_n;
	axi_mem_pkg::aw_req_t aw;
	logic                 aw_valid;
	logic                 aw_ready;
	axi_mem_pkg::w_beat_t w;
	logic                 w_valid;
	logic                 w_ready;
	axi_mem_pkg::id_t     b_id;
	logic                 b_valid;
	logic                 b_ready;
	axi_mem_pkg::ar_req_t ar;
	logic                 ar_valid;
	logic                 ar_ready;
	axi_mem_pkg::r_beat_t r;
	logic                 r_valid;
	logic                 r_ready;

	// bursts as read from the data file
	logic               op_write [MAX_OPS];
	axi_mem_pkg::id_t   op_id [MAX_OPS];
	axi_mem_pkg::addr_t op_line [MAX_OPS];
	axi_mem_pkg::len_t  op_len [MAX_OPS];
	int                 op_phase [MAX_OPS];
	int                 op_beats [MAX_OPS];
	axi_mem_pkg::data_t op_data [MAX_OPS][2];
	axi_mem_pkg::strb_t op_strb [MAX_OPS][2];
	int                 nops;
	int                 nlines;
	int                 last_phase;

	// write IDs still owed a response in issue order
	axi_mem_pkg::id_t exp_b [$];
	axi_mem_pkg::id_t exp_id;

	integer seed;
	int     errors;
	int     checks;
	int     cycles;
	int     limit;

	// channels seen stalled on the previous edge
	logic                 b_hold;
	axi_mem_pkg::id_t     b_id_q;
	logic                 r_hold;
	axi_mem_pkg::r_beat_t r_q;

	axi_mem_top #(
		.LINE_ADDR_W(10),
		.BQ_DEPTH(4)
	) dut0 (
		.clk(clk),
		.rst_n(rst_n),
		.aw(aw),
		.aw_valid(aw_valid),
		.aw_ready(aw_ready),
		.w(w),
		.w_valid(w_valid),
		.w_ready(w_ready),
		.b_id(b_id),
		.b_valid(b_valid),
		.b_ready(b_ready),
		.ar(ar),
		.ar_valid(ar_valid),
		.ar_ready(ar_ready),
		.r(r),
		.r_valid(r_valid),
		.r_ready(r_ready)
	);

	always #4 clk = ~clk;

	task automatic check_value(input string name, input logic [263:0] got,
			input logic [263:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic load_ops();
		integer             fd;
		integer             code;
		logic [63:0]        tok;
		logic [8*200-1:0]   skip;
		axi_mem_pkg::data_t f_data;
		axi_mem_pkg::strb_t f_strb;
		int                 k;
		fd = $fopen("tests/axi_mem_testdata.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("cannot open tests/axi_mem_testdata.txt");
		end else begin
			code = $fscanf(fd, "%s", tok);
			while (code == 1) begin
				nlines++;
				if (tok == "#") begin
					code = $fgets(skip, fd);
				end else if ((tok == "W" || tok == "R") && nops < MAX_OPS) begin
					code = $fscanf(fd, "%h %h %h", op_id[nops], op_line[nops], op_len[nops]);
					op_write[nops] = (tok == "W");
					op_phase[nops] = last_phase;
					op_beats[nops] = 0;
					nops++;
				end else if ((tok == "D" || tok == "E") && nops > 0 && op_beats[nops-1] < 2) begin
					k = op_beats[nops-1];
					f_strb = '0;
					if (tok == "D") begin
						code = $fscanf(fd, "%h %h", f_data, f_strb);
					end else begin
						code = $fscanf(fd, "%h", f_data);
					end
					op_data[nops-1][k] = f_data;
					op_strb[nops-1][k] = f_strb;
					op_beats[nops-1] = k + 1;
				end else if (tok == "P") begin
					last_phase++;
				end else begin
					errors++;
					$display("data file record %0d is not a valid record", nlines);
				end
				code = $fscanf(fd, "%s", tok);
			end
			$fclose(fd);
		end
	endtask

	task automatic write_burst(input int i);
		aw.id = op_id[i];
		aw.addr = op_line[i] << LINE_SHIFT;
		aw.len = op_len[i];
		aw_valid = 1'b1;
		@(posedge clk);
		while (!aw_ready) begin
			@(posedge clk);
		end
		// response owed from here on in issue order
		exp_b.push_back(op_id[i]);
		#1;
		aw_valid = 1'b0;
		// no new burst while the data phase is open
		check_value("aw_ready", aw_ready, 1'b0);
		for (int k = 0; k <= op_len[i]; k++) begin
			w.data = op_data[i][k];
			w.strb = op_strb[i][k];
			w_valid = 1'b1;
			@(posedge clk);
			while (!w_ready) begin
				@(posedge clk);
			end
			#1;
		end
		w_valid = 1'b0;
	endtask

	task automatic read_burst(input int i);
		ar.id = op_id[i];
		ar.addr = op_line[i] << LINE_SHIFT;
		ar.len = op_len[i];
		ar_valid = 1'b1;
		@(posedge clk);
		while (!ar_ready) begin
			@(posedge clk);
		end
		#1;
		ar_valid = 1'b0;
		// read burst open until its last beat goes
		check_value("ar_ready", ar_ready, 1'b0);
		for (int k = 0; k <= op_len[i]; k++) begin
			@(posedge clk);
			while (!(r_valid && r_ready)) begin
				@(posedge clk);
			end
			check_value("r.id", r.id, op_id[i]);
			check_value("r.data", r.data, op_data[i][k]);
			// last only on the final beat
			check_value("r.last", r.last, (k == op_len[i]));
		end
		#1;
	endtask

	task automatic write_stream(input int ph);
		for (int i = 0; i < nops; i++) begin
			if (op_write[i] && op_phase[i] == ph) begin
				write_burst(i);
			end
		end
	endtask

	task automatic read_stream(input int ph);
		for (int i = 0; i < nops; i++) begin
			if (!op_write[i] && op_phase[i] == ph) begin
				read_burst(i);
			end
		end
	endtask

	// random back-pressure on b and r about one cycle in four
	always @(posedge clk) begin
		#1;
		b_ready = ($random(seed) & 3) != 0;
		r_ready = ($random(seed) & 3) != 0;
	end

	// response order and held channels
	always @(posedge clk) begin
		if (rst_n) begin
			if (b_hold) begin
				check_value("b_valid", b_valid, 1'b1);
				check_value("b_id", b_id, b_id_q);
			end
			if (r_hold) begin
				check_value("r_valid", r_valid, 1'b1);
				check_value("r", r, r_q);
			end
			if (b_valid && b_ready) begin
				checks++;
				assert (exp_b.size() != 0) else begin
					errors++;
					$display("write response with b_id %h at %0t has no burst behind it",
						b_id, $time);
				end
				if (exp_b.size() != 0) begin
					exp_id = exp_b.pop_front();
					check_value("b_id", b_id, exp_id);
				end
			end
			b_hold = b_valid && !b_ready;
			b_id_q = b_id;
			r_hold = r_valid && !r_ready;
			r_q = r;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= limit) begin
			$display("timeout after %0d cycles with bursts still open", cycles);
			$display("test failed");
			$finish;
		end
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		aw = '0;
		aw_valid = 1'b0;
		w = '0;
		w_valid = 1'b0;
		b_ready = 1'b0;
		ar = '0;
		ar_valid = 1'b0;
		r_ready = 1'b0;
		seed = 32'h1ed8_53df;
		errors = 0;
		checks = 0;
		cycles = 0;
		limit = 100000;
		nops = 0;
		nlines = 0;
		last_phase = 0;
		b_hold = 1'b0;
		r_hold = 1'b0;
		load_ops();
		limit = 40 * nlines + 200;
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;
		// idle levels out of reset
		check_value("aw_ready", aw_ready, 1'b1);
		check_value("ar_ready", ar_ready, 1'b1);
		check_value("w_ready", w_ready, 1'b0);
		check_value("b_valid", b_valid, 1'b0);
		check_value("r_valid", r_valid, 1'b0);
		// phases keep the overlapping streams off each other's lines
		for (int p = 0; p <= last_phase; p++) begin
			fork
				write_stream(p);
				read_stream(p);
			join
		end
		while (exp_b.size() != 0) begin
			@(posedge clk);
		end
		@(posedge clk);
		#1;
		// nothing left over on either response channel
		check_value("b_valid", b_valid, 1'b0);
		check_value("r_valid", r_valid, 1'b0);
		$display("errors: %0d, checks: %0d", errors, checks);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
